// ==== rvlite.f ====
+incdir+hdl
hdl/rvlite_pkg.sv
hdl/control_fsm.sv
hdl/pc_counter.sv
hdl/instruction_decoder.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/rvlite_core.sv
testbench/rvlite_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the rvlite testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rvlite_tb \
    -f rvlite.f -o rvlite_sim

sim_output=$(./obj_dir/rvlite_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "No errors"

// ==== testbench/rvlite_vectors.txt ====
# T <test name> | P <byte address hex> <instruction word hex>
# E <byte address hex> <expected word hex>
T alu_ops
P 000 06400093
P 004 ff900113
P 008 002081b3
P 00c 40208233
P 010 0020f2b3
P 014 0020e333
P 018 0020c3b3
P 01c 00112433
P 020 00300513
P 024 00a094b3
P 028 00a155b3
P 02c 00f0f613
P 030 1000e693
P 034 fff0c713
P 038 ffa12793
P 03c 12345837
P 040 00001897
P 044 20302023
P 048 20402223
P 04c 20502423
P 050 20602623
P 054 20702823
P 058 20802a23
P 05c 20902c23
P 060 20b02e23
P 064 22c02023
P 068 22d02223
P 06c 22e02423
P 070 22f02623
P 074 23002823
P 078 23102a23
P 07c 00000073
E 200 0000005d
E 204 0000006b
E 208 00000060
E 20c fffffffd
E 210 ffffff9d
E 214 00000001
E 218 00000320
E 21c 1fffffff
E 220 00000004
E 224 00000164
E 228 ffffff9b
E 22c 00000001
E 230 12345000
E 234 00001040
T load_store_x0
P 000 cafeb0b7
P 004 12308093
P 008 20102023
P 00c 20002103
P 010 00110193
P 014 20302223
P 018 03700013
P 01c 20002003
P 020 00200233
P 024 20002423
P 028 20402623
P 02c 00000073
E 200 cafeb123
E 204 cafeb124
E 208 00000000
E 20c cafeb123
T branch_jump
P 000 00500093
P 004 ffd00113
P 008 00108463
P 00c 00156513
P 010 00208463
P 014 00256513
P 018 00209463
P 01c 00456513
P 020 00109463
P 024 00856513
P 028 00114463
P 02c 01056513
P 030 0020c463
P 034 02056513
P 038 0020d463
P 03c 04056513
P 040 00115463
P 044 08056513
P 048 20a02023
P 04c 0080036f
P 050 00000313
P 054 20602223
P 058 06800393
P 05c 00038467
P 060 00000413
P 064 00000413
P 068 20802423
P 06c 00000073
E 200 000000aa
E 204 00000050
E 208 00000060

// ==== testbench/rvlite_tb.sv ====
// rvlite testbench: Wishbone memory with random wait states running programs from a vector file
`timescale 1ns/1ns
`default_nettype none

`include "rvlite_macros.svh"

module rvlite_tb
    import rvlite_pkg::*;
();

    localparam int    MEM_WORDS    = 1024;
    localparam int    RESET_CYCLES = 10;
    localparam int    MAX_WAIT     = 3;
    localparam int    CLK_PERIOD   = 8;
    localparam int    SEED         = 34;
    localparam string VECTOR_FILE  = "testbench/rvlite_vectors.txt";

    logic        clk;
    logic        reset;
    wb_master_t  wb_m;
    wb_slave_t   wb_s;
    logic        halted;

    // Word memory, byte address bits 11:2 pick the word
    logic [31:0] mem [MEM_WORDS];
    bit          busy;
    int          wait_left;

    // Parsed vectors
    string       test_names [$];
    int          prog_test [$];
    logic [31:0] prog_addr [$];
    logic [31:0] prog_data [$];
    int          exp_test [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    string       active_test;
    int          errors;
    int          test_errors;
    int          tests_failed;
    longint      watchdog_ns;

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    rvlite_core i_dut (
        .clk    (clk),
        .reset  (reset),
        .wb_s   (wb_s),
        .wb_m   (wb_m),
        .halted (halted)
    );

    // ----------------------------------------------------------
    // Wishbone memory, acts on the falling edge
    // ----------------------------------------------------------
    always @(negedge clk)
    begin
        if (reset)
        begin
            wb_s.ack = 1'b0;
            busy = 1'b0;
        end
        else if (wb_s.ack)
        begin
            // Master drops cyc on the edge that saw ack
            wb_s.ack = 1'b0;
            busy = 1'b0;
        end
        else if (wb_m.cyc && wb_m.stb)
        begin
            if (!busy)
            begin
                busy = 1'b1;
                wait_left = $urandom % (MAX_WAIT + 1);
            end
            if (wait_left == 0)
            begin
                // Every access is a full word
                assert (wb_m.sel == {`RV_SEL_W{1'b1}})
                else
                begin
                    $display("Mismatch %s byte select at %h expected %h actual %h",
                             active_test, wb_m.adr, {`RV_SEL_W{1'b1}}, wb_m.sel);
                    test_errors++;
                end
                if (wb_m.we)
                    mem[wb_m.adr[11:2]] = wb_m.dat_w;
                else
                    wb_s.dat_r = mem[wb_m.adr[11:2]];
                wb_s.ack = 1'b1;
            end
            else
                wait_left--;
        end
    end

    // ----------------------------------------------------------
    // Vector file reader
    // ----------------------------------------------------------
    task automatic read_vectors();
        int          fd;
        string       line;
        string       kind;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0)
        begin
            $display("Cannot open vector file %s", VECTOR_FILE);
            errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                kind = "";
                void'($fgets(line, fd));
                void'($sscanf(line, "%s", kind));
                if (kind == "T")
                begin
                    void'($sscanf(line, "%s %s", kind, name));
                    test_names.push_back(name);
                end
                else if (kind == "P")
                begin
                    void'($sscanf(line, "%s %h %h", kind, a, d));
                    prog_test.push_back(test_names.size() - 1);
                    prog_addr.push_back(a);
                    prog_data.push_back(d);
                end
                else if (kind == "E")
                begin
                    void'($sscanf(line, "%s %h %h", kind, a, d));
                    exp_test.push_back(test_names.size() - 1);
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    // Fill pattern from the word index, then the test's program on top
    task automatic load_memory(input int t);
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'h5a00_0000 | 32'(i);
        for (int i = 0; i < prog_data.size(); i++)
            if (prog_test[i] == t)
                mem[prog_addr[i][11:2]] = prog_data[i];
    endtask

    // ----------------------------------------------------------
    // Reset and first fetch
    // ----------------------------------------------------------
    task automatic apply_reset(input string name);
        @(negedge clk);
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        assert (!wb_m.cyc && !wb_m.stb && !halted)
        else
        begin
            $display("%s: bus or halted not idle during reset", name);
            test_errors++;
        end
        reset = 1'b0;
        // cyc rises on the first edge after reset falls
        @(negedge clk);
        assert (wb_m.cyc && wb_m.stb)
        else
        begin
            $display("%s: no bus cycle on the first cycle after reset", name);
            test_errors++;
        end
        assert (wb_m.adr == `RV_RESET_ADDRESS)
        else
        begin
            $display("Mismatch %s first fetch address expected %h actual %h",
                     name, `RV_RESET_ADDRESS, wb_m.adr);
            test_errors++;
        end
    endtask

    // ----------------------------------------------------------
    // One test: load, run to halt, compare memory
    // ----------------------------------------------------------
    task automatic run_test(input int t);
        string name;
        name = test_names[t];
        active_test = name;
        test_errors = 0;
        load_memory(t);
        apply_reset(name);
        // Watchdog bounds this wait
        while (!halted)
            @(negedge clk);
        // Bus stays idle once halted
        repeat (4)
        begin
            @(negedge clk);
            assert (halted && !wb_m.cyc)
            else
            begin
                $display("%s: bus active or halted dropped after SYSTEM", name);
                test_errors++;
            end
        end
        for (int i = 0; i < exp_data.size(); i++)
        begin
            if (exp_test[i] == t)
            begin
                assert (mem[exp_addr[i][11:2]] == exp_data[i])
                else
                begin
                    $display("Mismatch %s at %h expected %h actual %h",
                             name, exp_addr[i], exp_data[i], mem[exp_addr[i][11:2]]);
                    test_errors++;
                end
            end
        end
        if (test_errors == 0)
            $display("Test %s: pass", name);
        else
        begin
            $display("Test %s: %0d failing checks", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
    endtask

    // ----------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------
    initial
    begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout after %0d ns, core never halted", watchdog_ns);
        $display("Errors found");
        $finish;
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial
    begin
        void'($urandom(SEED));
        reset = 1'b1;
        wb_s = '0;
        busy = 1'b0;
        wait_left = 0;
        errors = 0;
        tests_failed = 0;
        watchdog_ns = 0;
        read_vectors();
        // Worst case per word plus reset time per test
        watchdog_ns = longint'(prog_data.size()) * (5 + 2 * MAX_WAIT) * CLK_PERIOD
                    + longint'(test_names.size()) * (RESET_CYCLES + 10) * CLK_PERIOD
                    + 500;
        for (int t = 0; t < test_names.size(); t++)
            run_test(t);
        $display("Tests %0d, failed %0d, failing checks %0d",
                 test_names.size(), tests_failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/rvlite_core.sv ====
// rvlite core top: multi-cycle RV32I subset with one Wishbone classic master port
`timescale 1ns/1ns
`default_nettype none

`include "rvlite_macros.svh"

module rvlite_core
    import rvlite_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire wb_slave_t wb_s,
    output wb_master_t     wb_m,
    output logic           halted
);

    state_e              state;
    decoded_t            dec;
    logic                cyc;
    logic                stb;
    logic                we;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic                taken;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                rd_write;
    logic [`RV_XLEN-1:0] rd_data;
    logic [`RV_XLEN-1:0] adr;
    logic [`RV_XLEN-1:0] dat_w;
    logic [`RV_SEL_W-1:0] sel;

    // ----------------------------------------------------------
    // Sequencing
    // ----------------------------------------------------------
    control_fsm i_control_fsm (
        .clk    (clk),
        .reset  (reset),
        .dec    (dec),
        .ack    (wb_s.ack),
        .state  (state),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .halted (halted)
    );

    pc_counter i_pc_counter (
        .clk      (clk),
        .reset    (reset),
        .state    (state),
        .taken    (taken),
        .target   (target),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------
    instruction_decoder i_instruction_decoder (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .ack   (wb_s.ack),
        .dat_r (wb_s.dat_r),
        .dec   (dec)
    );

    register_file i_register_file (
        .clk          (clk),
        .reset        (reset),
        .rs1_index    (dec.rs1),
        .rs2_index    (dec.rs2),
        .rd_index     (dec.rd),
        .write_enable (rd_write),
        .write_data   (rd_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    execute_unit i_execute_unit (
        .clk      (clk),
        .reset    (reset),
        .state    (state),
        .dec      (dec),
        .pc       (pc),
        .pc_plus4 (pc_plus4),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_s     (wb_s),
        .adr      (adr),
        .dat_w    (dat_w),
        .sel      (sel),
        .taken    (taken),
        .target   (target),
        .rd_write (rd_write),
        .rd_data  (rd_data)
    );

    // Control bits from the FSM, address and data from the execute unit
    assign wb_m.cyc   = cyc;
    assign wb_m.stb   = stb;
    assign wb_m.we    = we;
    assign wb_m.adr   = adr;
    assign wb_m.dat_w = dat_w;
    assign wb_m.sel   = sel;

endmodule

`default_nettype wire

// ==== hdl/execute_unit.sv ====
// Execute unit: ALU, branch compare, address generation, bus address and writeback select
`timescale 1ns/1ns
`default_nettype none

`include "rvlite_macros.svh"

module execute_unit
    import rvlite_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire state_e              state,
    input  wire decoded_t            dec,
    input  wire logic [`RV_XLEN-1:0] pc,
    input  wire logic [`RV_XLEN-1:0] pc_plus4,
    input  wire logic [`RV_XLEN-1:0] rs1_data,
    input  wire logic [`RV_XLEN-1:0] rs2_data,
    input  wire wb_slave_t           wb_s,
    output logic [`RV_XLEN-1:0]      adr,
    output logic [`RV_XLEN-1:0]      dat_w,
    output logic [`RV_SEL_W-1:0]     sel,
    output logic                     taken,
    output logic [`RV_XLEN-1:0]      target,
    output logic                     rd_write,
    output logic [`RV_XLEN-1:0]      rd_data
);

    logic [`RV_XLEN-1:0] operand_b;
    logic [`RV_XLEN-1:0] alu_out;
    logic [`RV_XLEN-1:0] addr_sum;
    logic                branch_ok;
    logic [`RV_XLEN-1:0] result_q;
    logic [`RV_XLEN-1:0] addr_q;
    logic [`RV_XLEN-1:0] load_q;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    assign operand_b = (dec.opcode == OPC_OP) ? rs2_data : dec.imm;

    always_comb
    begin
        case (dec.alu_op)
            ALU_SUB: alu_out = rs1_data - operand_b;
            ALU_AND: alu_out = rs1_data & operand_b;
            ALU_OR:  alu_out = rs1_data | operand_b;
            ALU_XOR: alu_out = rs1_data ^ operand_b;
            ALU_SLT: alu_out = {31'b0, $signed(rs1_data) < $signed(operand_b)};
            ALU_SLL: alu_out = rs1_data << operand_b[4:0];
            ALU_SRL: alu_out = rs1_data >> operand_b[4:0];
            default: alu_out = rs1_data + operand_b;
        endcase
    end

    // ----------------------------------------------------------
    // Branch compare and address
    // ----------------------------------------------------------

    // BEQ, BNE, BLT, BGE; other funct3 codes never branch
    always_comb
    begin
        case (dec.funct3)
            3'b000:  branch_ok = (rs1_data == rs2_data);
            3'b001:  branch_ok = (rs1_data != rs2_data);
            3'b100:  branch_ok = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_ok = ($signed(rs1_data) >= $signed(rs2_data));
            default: branch_ok = 1'b0;
        endcase
    end

    // pc-relative for JAL, branches and AUIPC; rs1-relative for JALR and memory
    assign addr_sum = ((dec.opcode == OPC_JAL || dec.opcode == OPC_BRANCH ||
                        dec.opcode == OPC_AUIPC) ? pc : rs1_data) + dec.imm;

    // ----------------------------------------------------------
    // Execute and memory registers
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            taken <= 1'b0;
        else if (state == ST_EXECUTE)
            taken <= (dec.opcode == OPC_JAL) || (dec.opcode == OPC_JALR) ||
                     (dec.opcode == OPC_BRANCH && branch_ok);
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_EXECUTE)
        begin
            result_q <= alu_out;
            addr_q   <= addr_sum;
        end
        // Load data arrives with the memory ack
        if (state == ST_MEMORY && wb_s.ack)
            load_q <= wb_s.dat_r;
    end

    // Word aligned jump and branch target
    assign target = {addr_q[`RV_XLEN-1:2], 2'b00};

    // ----------------------------------------------------------
    // Bus fields
    // ----------------------------------------------------------
    assign adr   = (state == ST_FETCH) ? pc : addr_q;
    assign dat_w = rs2_data;
    // Word accesses only
    assign sel   = '1;

    // ----------------------------------------------------------
    // Writeback select
    // ----------------------------------------------------------
    assign rd_write = (state == ST_WRITEBACK) && dec.writes_rd;

    always_comb
    begin
        case (dec.opcode)
            OPC_JAL, OPC_JALR: rd_data = pc_plus4;
            OPC_AUIPC:         rd_data = addr_q;
            OPC_LUI:           rd_data = dec.imm;
            OPC_LOAD:          rd_data = load_q;
            default:           rd_data = result_q;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
// Register file: 32 general registers, two read ports and one write port, x0 fixed at zero
`timescale 1ns/1ns
`default_nettype none

`include "rvlite_macros.svh"

module register_file
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [`RV_REG_INDEX_W-1:0] rs1_index,
    input  wire logic [`RV_REG_INDEX_W-1:0] rs2_index,
    input  wire logic [`RV_REG_INDEX_W-1:0] rd_index,
    input  wire logic                       write_enable,
    input  wire logic [`RV_XLEN-1:0]        write_data,
    output logic [`RV_XLEN-1:0]             rs1_data,
    output logic [`RV_XLEN-1:0]             rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // Writes to x0 are dropped so its entry keeps the reset zero
    always_ff @(posedge clk)
    begin
        if (reset)
            regs <= '{default: '0};
        else if (write_enable && rd_index != '0)
            regs[rd_index] <= write_data;
    end

    // Combinational reads
    assign rs1_data = regs[rs1_index];
    assign rs2_data = regs[rs2_index];

    // x0 holds zero through every write, including writes aimed at it
    a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

// ==== hdl/instruction_decoder.sv ====
// Instruction decoder: holds the fetched word and splits it into fields and an immediate
`timescale 1ns/1ns
`default_nettype none

`include "rvlite_macros.svh"

module instruction_decoder
    import rvlite_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire state_e              state,
    input  wire logic                ack,
    input  wire logic [`RV_XLEN-1:0] dat_r,
    output decoded_t                 dec
);

    // ADDI x0, x0, 0
    localparam logic [`RV_XLEN-1:0] NOP_WORD = 32'h0000_0013;

    logic [`RV_XLEN-1:0] ir;
    opcode_e             opcode;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // ----------------------------------------------------------
    // Instruction register
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            ir <= NOP_WORD;
        else if (state == ST_FETCH && ack)
            ir <= dat_r;
    end

    // ----------------------------------------------------------
    // Opcode and immediates
    // ----------------------------------------------------------

    // Opcodes outside the kept set fold to unknown
    always_comb
    begin
        case (ir[6:0])
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL,
            OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_SYSTEM:
                opcode = opcode_e'(ir[6:0]);
            default:
                opcode = OPC_UNKNOWN;
        endcase
    end

    // Sign-extended immediates by format
    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // ----------------------------------------------------------
    // Decoded fields
    // ----------------------------------------------------------
    always_comb
    begin
        dec.opcode = opcode;
        dec.funct3 = ir[14:12];
        dec.rd     = ir[11:7];
        dec.rs1    = ir[19:15];
        dec.rs2    = ir[24:20];

        // ALU op from funct3, SUB only for register form
        dec.alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM)
        begin
            case (ir[14:12])
                3'b000: dec.alu_op = (opcode == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = ALU_SRL;
                3'b110: dec.alu_op = ALU_OR;
                3'b111: dec.alu_op = ALU_AND;
                default: dec.alu_op = ALU_ADD;
            endcase
        end

        case (opcode)
            OPC_STORE:             dec.imm = imm_s;
            OPC_BRANCH:            dec.imm = imm_b;
            OPC_LUI, OPC_AUIPC:    dec.imm = imm_u;
            OPC_JAL:               dec.imm = imm_j;
            default:               dec.imm = imm_i;
        endcase

        // Stores, branches, SYSTEM and unknown ops leave the registers alone
        case (opcode)
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD:
                dec.writes_rd = (ir[11:7] != '0);
            default:
                dec.writes_rd = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/pc_counter.sv ====
// Program counter: steps by four or loads a branch or jump target at writeback
`timescale 1ns/1ns
`default_nettype none

`include "rvlite_macros.svh"

module pc_counter
    import rvlite_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire state_e              state,
    input  wire logic                taken,
    input  wire logic [`RV_XLEN-1:0] target,
    output logic [`RV_XLEN-1:0]      pc,
    output logic [`RV_XLEN-1:0]      pc_plus4
);

    // Sequential address, also the link value for jumps
    assign pc_plus4 = pc + `RV_XLEN'd4;

    // pc moves only on the writeback edge
    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `RV_RESET_ADDRESS;
        else if (state == ST_WRITEBACK)
            pc <= taken ? target : pc_plus4;
    end

    // Targets from the execute unit keep fetches word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/control_fsm.sv ====
// Control FSM: steps each instruction through its states and runs the Wishbone handshake
`timescale 1ns/1ns
`default_nettype none

module control_fsm
    import rvlite_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire decoded_t dec,
    input  wire logic     ack,
    output state_e        state,
    output logic          cyc,
    output logic          stb,
    output logic          we,
    output logic          halted
);

    state_e next_state;

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            // Bus states wait out any number of slave wait states
            ST_FETCH:
                if (ack)
                    next_state = ST_DECODE;
            // Register read settles here
            ST_DECODE:
                next_state = ST_EXECUTE;
            ST_EXECUTE:
                if (dec.opcode == OPC_LOAD || dec.opcode == OPC_STORE)
                    next_state = ST_MEMORY;
                else if (dec.opcode == OPC_SYSTEM)
                    next_state = ST_HALT;
                else
                    next_state = ST_WRITEBACK;
            ST_MEMORY:
                if (ack)
                    next_state = ST_WRITEBACK;
            ST_WRITEBACK:
                next_state = ST_FETCH;
            // Only reset leaves HALT
            default:
                next_state = ST_HALT;
        endcase
    end

    // ----------------------------------------------------------
    // State and bus control registers
    // ----------------------------------------------------------

    // cyc and stb follow the next state so they rise on entry to a bus state
    // and drop on the edge after ack
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_FETCH;
            cyc   <= 1'b0;
            stb   <= 1'b0;
            we    <= 1'b0;
        end
        else
        begin
            state <= next_state;
            cyc   <= (next_state == ST_FETCH) || (next_state == ST_MEMORY);
            stb   <= (next_state == ST_FETCH) || (next_state == ST_MEMORY);
            // Write only for a store data cycle
            we    <= (next_state == ST_MEMORY) && (dec.opcode == OPC_STORE);
        end
    end

    assign halted = (state == ST_HALT);

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    // Strobe stays inside the cycle with a steady direction until ack
    a_stb_hold: assert property (@(posedge clk) disable iff (reset)
        (stb && !ack) |=> (stb && cyc && $stable(we)));

    // A started cycle holds until the slave acknowledges
    a_cyc_until_ack: assert property (@(posedge clk) disable iff (reset)
        (cyc && !ack) |=> cyc);

    // Once halted the bus stays idle
    a_halt_idle: assert property (@(posedge clk) disable iff (reset)
        halted |=> (halted && !cyc));

endmodule

`default_nettype wire

// ==== hdl/rvlite_pkg.sv ====
// rvlite types: opcode, FSM state and ALU enums, decode and Wishbone structs
`default_nettype none

`include "rvlite_macros.svh"

package rvlite_pkg;

    // ----------------------------------------------------------
    // Enumerations
    // ----------------------------------------------------------

    // Major opcodes, encoded as in the RV32I base
    typedef enum logic [6:0] {
        OPC_OP      = 7'b0110011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_BRANCH  = 7'b1100011,
        OPC_LOAD    = 7'b0000011,
        OPC_STORE   = 7'b0100011,
        OPC_SYSTEM  = 7'b1110011,
        // Anything else runs as a no-op
        OPC_UNKNOWN = 7'b0000000
    } opcode_e;

    // Instruction sequencing states
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALT
    } state_e;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // ----------------------------------------------------------
    // Structures
    // ----------------------------------------------------------

    // Decoded instruction, shared by FSM, register file and execute unit
    typedef struct packed {
        opcode_e                     opcode;
        alu_op_e                     alu_op;
        // Branch kind
        logic [2:0]                  funct3;
        logic [`RV_REG_INDEX_W-1:0]  rd;
        logic [`RV_REG_INDEX_W-1:0]  rs1;
        logic [`RV_REG_INDEX_W-1:0]  rs2;
        logic [`RV_XLEN-1:0]         imm;
        logic                        writes_rd;
    } decoded_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`RV_XLEN-1:0]   adr;
        logic [`RV_XLEN-1:0]   dat_w;
        logic [`RV_SEL_W-1:0]  sel;
    } wb_master_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic [`RV_XLEN-1:0] dat_r;
        logic                ack;
    } wb_slave_t;

endpackage

`default_nettype wire

// ==== hdl/rvlite_macros.svh ====
// rvlite macros: core widths, register count and reset address
`ifndef RVLITE_MACROS_SVH
`define RVLITE_MACROS_SVH

// ----------------------------------------------------------
// Datapath
// ----------------------------------------------------------

// Data and address width
`define RV_XLEN 32

// Register file depth and index width
`define RV_REG_COUNT 32
`define RV_REG_INDEX_W 5

// ----------------------------------------------------------
// Bus and boot
// ----------------------------------------------------------

// First fetch address after reset
`define RV_RESET_ADDRESS 32'h0000_0000

// Wishbone byte-select width, one bit per byte lane
`define RV_SEL_W 4

`endif
